// File: adpll_grid.f
+incdir+.
adpll_grid_pkg.sv
grid_config.sv
ref_nco.sv
loop_filter.sv
pll_node.sv
adpll_grid_top.sv
tb_clock_gen.sv
tb_adpll_grid.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the grid testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_adpll_grid \
    -f adpll_grid.f \
    -Mdir obj_dir -o sim_adpll_grid

./obj_dir/sim_adpll_grid | tee sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
if ! grep -q "TESTBENCH PASSED" sim.log; then
    echo "simulation ended without a result line"
    exit 1
fi
echo "simulation passed"

// File: tb_adpll_grid.sv
`include "adpll_grid_settings.svh"

module tb_adpll_grid;

    localparam int drive_dly  = 10;
    // reset, idle, step loads, free running, locking, network, enable drops
    localparam int max_cycles = 2 + 40 + 8 * 20 + 100 + 2 * 3 * 151 + 8 * 200 + 3 * 143;

    // weights left above right below per node from 11 to 33
    localparam int uni_w [9][4] = '{
        '{4, 0, 0, 0}, '{4, 0, 0, 0}, '{4, 0, 0, 0},
        '{0, 4, 0, 0}, '{2, 2, 0, 0}, '{2, 2, 0, 0},
        '{0, 4, 0, 0}, '{2, 2, 0, 0}, '{2, 2, 0, 0}
    };
    localparam int mesh_w [9][4] = '{
        '{2, 0, 1, 1}, '{1, 0, 1, 1}, '{2, 0, 0, 2},
        '{0, 1, 1, 1}, '{1, 1, 1, 1}, '{1, 1, 0, 1},
        '{0, 2, 2, 0}, '{1, 2, 1, 0}, '{2, 2, 0, 0}
    };
    localparam int step_off [9] = '{0, 2, 18, 12, 10, -4, 0, 8, 0};

    logic        clk258_x;
    logic        rst_n;
    logic [15:0] switches;
    logic [8:0]  gen_clk;
    logic        ref_clk;

    // model state
    int m_phase [9];
    int m_integ [9];
    int m_ref;
    bit m_en;
    bit m_net;
    bit m_uni;
    int m_kp;
    int m_ki;
    int m_step;

    int checks;
    int mismatches;
    int other_errors;
    int cycle_count;

    tb_clock_gen u_clk (
        .clk_o   (clk258_x),
        .rst_n_o (rst_n)
    );

    adpll_grid_top DUT (
        .clk258_x   (clk258_x),
        .rst_n_i    (rst_n),
        .switches_i (switches),
        .gen_clk_o  (gen_clk),
        .ref_clk_o  (ref_clk)
    );

    function automatic int wrap_signed(input int v, input int bits);
        int r;
        r = v & ((1 << bits) - 1);
        if (r >= (1 << (bits - 1)))
            r = r - (1 << bits);
        return r;
    endfunction

    task automatic model_reset();
        for (int n = 0; n < 9; n++)
        begin
            m_phase[n] = 0;
            m_integ[n] = 0;
        end
        m_ref  = 0;
        m_en   = 1'b0;
        m_net  = 1'b0;
        m_uni  = 1'b0;
        m_kp   = 1;
        m_ki   = 1;
        m_step = `REF_STEP_RST;
    endtask

    // one clock edge of the whole grid with sw as the sampled switch word
    task automatic model_step(input logic [15:0] sw);
        int nxt_phase [9];
        int nxt_integ [9];
        int src [4];
        int r;
        int c;
        int own;
        int e;
        int w;
        int sum;
        int ctrl;
        for (int n = 0; n < 9; n++)
        begin
            r   = n / 3;
            c   = n % 3;
            own = m_phase[n];
            if (!m_en)
            begin
                nxt_phase[n] = 0;
                nxt_integ[n] = 0;
            end
            else
            begin
                src[2] = (c < 2) ? m_phase[n + 1] : own;
                src[3] = (r < 2) ? m_phase[n + 3] : own;
                if (!m_net)
                begin
                    src[0] = m_ref;
                    src[1] = m_ref;
                end
                else
                begin
                    src[0] = (n == 0) ? m_ref : ((c > 0) ? m_phase[n - 1] : own);
                    src[1] = (r > 0) ? m_phase[n - 3] : own;
                end
                sum = 0;
                for (int d = 0; d < 4; d++)
                begin
                    e   = wrap_signed((src[d] >> 7) - (own >> 7), 5);
                    w   = m_uni ? uni_w[n][d] : mesh_w[n][d];
                    sum = sum + w * e;
                end
                nxt_integ[n] = wrap_signed(m_integ[n] + m_ki * sum, 20);
                ctrl = wrap_signed(((m_kp * sum) >>> `KP_FRAC) + (m_integ[n] >>> `KI_FRAC), 12);
                nxt_phase[n] = (own + `BASE_STEP + step_off[n] + ctrl) & 'hfff;
            end
        end
        m_phase = nxt_phase;
        m_integ = nxt_integ;
        m_ref   = (m_ref + m_step) & 'hfff;
        m_en    = sw[15];
        m_uni   = sw[14];
        m_net   = sw[13];
        if (sw[12])
            m_step = int'(sw[11:0]);
        else
        begin
            m_kp = int'(sw[11:8]);
            m_ki = int'(sw[3:0]);
        end
    endtask

    task automatic check_outputs();
        logic [8:0] exp_gen;
        logic       exp_ref;
        for (int n = 0; n < 9; n++)
            exp_gen[n] = m_phase[n][11];    // phase MSB
        exp_ref = m_ref[11];
        checks = checks + 2;
        assert (gen_clk === exp_gen)
        else
        begin
            $display("MISMATCH gen_clk_o got 0x%h expected 0x%h at cycle %0d",
                     gen_clk, exp_gen, cycle_count);
            mismatches++;
        end
        assert (ref_clk === exp_ref)
        else
        begin
            $display("MISMATCH ref_clk_o got 0x%h expected 0x%h at cycle %0d",
                     ref_clk, exp_ref, cycle_count);
            mismatches++;
        end
    endtask

    task automatic tick(input logic [15:0] next_sw);
        @(posedge clk258_x);
        #(drive_dly);
        model_step(switches);
        check_outputs();
        switches = next_sw;
        cycle_count++;
    endtask

    function automatic logic [15:0] gains_word(input bit uni, input bit net,
                                               input logic [3:0] kp, input logic [3:0] ki);
        return {1'b1, uni, net, 1'b0, kp, 4'h0, ki};
    endfunction

    function automatic logic [15:0] step_word(input bit en, input bit uni, input bit net,
                                              input logic [11:0] step);
        return {en, uni, net, 1'b1, step};
    endfunction

    initial
    begin
        #(max_cycles * 100 * 2);
        $display("watchdog expired at cycle %0d, the run did not finish", cycle_count);
        $display("checks %0d, mismatches %0d, other errors %0d", checks, mismatches,
                 other_errors + 1);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial
    begin
        logic [15:0] w_on;
        logic [15:0] w_off;
        logic [11:0] ref_step;
        int          saved_kp;
        int          saved_ki;
        int          seg_len;
        bit          uni;

        checks       = 0;
        mismatches   = 0;
        other_errors = 0;
        cycle_count  = 0;
        switches     = 16'h0000;
        void'($urandom(32'hda51_fb97));
        model_reset();
        wait (rst_n === 1'b1);
        switches = 16'h0101;    // keeps kp = ki = 1

        // reset and idle
        repeat (40) tick(16'h0101);

        // each reference step held 20 cycles with enable low
        saved_kp = m_kp;
        saved_ki = m_ki;
        for (int i = 0; i < 8; i++)
        begin
            ref_step = 12'($urandom);
            repeat (20) tick(step_word(1'b0, 1'b0, 1'b0, ref_step));
        end
        checks++;
        assert (DUT.cfg.gains.kp == 4'(saved_kp) && DUT.cfg.gains.ki == 4'(saved_ki))
        else
        begin
            $display("gains changed while only reference steps were loaded");
            other_errors++;
        end

        // free running nodes with zero gains
        uni = 1'($urandom);
        repeat (100) tick(gains_word(uni, 1'b0, 4'h0, 4'h0));

        // single-PLL locking in mesh then uni coupling
        for (int k = 0; k < 2; k++)
        begin
            for (int s = 0; s < 3; s++)
            begin
                tick(step_word(1'b1, 1'(k), 1'b0, 12'(48 + $urandom_range(39, 0))));
                w_on = gains_word(1'(k), 1'b0, 4'($urandom_range(15, 1)),
                                  4'($urandom_range(15, 1)));
                repeat (150) tick(w_on);
            end
        end

        // network mode with random words held 50 to 200 cycles
        for (int s = 0; s < 8; s++)
        begin
            w_on    = 16'($urandom) | 16'ha000;
            seg_len = $urandom_range(200, 50);
            repeat (seg_len) tick(w_on);
        end

        // enable drop and restart
        for (int s = 0; s < 3; s++)
        begin
            w_on  = gains_word(1'($urandom), 1'($urandom), 4'($urandom_range(15, 1)),
                               4'($urandom_range(15, 1)));
            w_off = w_on & 16'h7fff;
            repeat (60) tick(w_on);
            repeat (3) tick(w_off);
            checks++;
            assert (gen_clk === 9'h000)
            else
            begin
                $display("MISMATCH gen_clk_o got 0x%h expected 0x000 after enable drop",
                         gen_clk);
                mismatches++;
            end
            repeat (80) tick(w_on);
        end

        $display("checks %0d, mismatches %0d, other errors %0d", checks, mismatches,
                 other_errors);
        if (mismatches == 0 && other_errors == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// File: tb_clock_gen.sv
module tb_clock_gen (
    output logic clk_o,
    output logic rst_n_o
);

    initial
    begin
        clk_o = 1'b0;
        forever #50 clk_o = ~clk_o;    // period 100
    end

    // reset held over the first two rising edges
    initial
    begin
        rst_n_o = 1'b0;
        repeat (2) @(posedge clk_o);
        #10 rst_n_o = 1'b1;
    end

endmodule

// File: adpll_grid_top.sv
`include "adpll_grid_settings.svh"

module adpll_grid_top (
    input  logic        clk258_x,
    input  logic        rst_n_i,
    input  logic [15:0] switches_i,
    output logic [8:0]  gen_clk_o,
    output logic        ref_clk_o
);

    // ring-size offsets, node 11 first
    localparam int step_offset [9] = '{0, 2, 18, 12, 10, -4, 0, 8, 0};

    adpll_grid_pkg::grid_cfg_t     cfg;
    adpll_grid_pkg::node_weights_t weights [9];
    adpll_grid_pkg::phase_t        ref_phase;
    adpll_grid_pkg::phase_t        node_phase [3][3];

    grid_config u_config (
        .clk258_x   (clk258_x),
        .rst_n_i    (rst_n_i),
        .switches_i (switches_i),
        .cfg_o      (cfg),
        .weights_o  (weights)
    );

    ref_nco u_ref (
        .clk258_x   (clk258_x),
        .rst_n_i    (rst_n_i),
        .ref_step_i (cfg.ref_step),
        .phase_o    (ref_phase)
    );

    for (genvar r = 0; r < 3; r++)
    begin : g_row
        for (genvar c = 0; c < 3; c++)
        begin : g_col
            // missing neighbours fold back onto the node itself
            localparam int idx = r * 3 + c;
            localparam int lc  = (c > 0) ? c - 1 : c;
            localparam int rc  = (c < 2) ? c + 1 : c;
            localparam int ur  = (r > 0) ? r - 1 : r;
            localparam int br  = (r < 2) ? r + 1 : r;
            localparam bit entry = (r == 0) && (c == 0);   // reference enters at 11

            adpll_grid_pkg::neighbour_phases_t nbr;

            always_comb
            begin
                nbr.right = node_phase[r][rc];
                nbr.below = node_phase[br][c];
                if (cfg.grid_mode == adpll_grid_pkg::GRID_PLL)
                begin
                    nbr.ref_left  = ref_phase;
                    nbr.ref_above = ref_phase;
                end
                else
                begin
                    nbr.ref_left  = entry ? ref_phase : node_phase[r][lc];
                    nbr.ref_above = node_phase[ur][c];
                end
            end

            pll_node #(
                .free_step (`BASE_STEP + step_offset[idx])
            ) u_node (
                .clk258_x  (clk258_x),
                .rst_n_i   (rst_n_i),
                .enable_i  (cfg.enable),
                .gains_i   (cfg.gains),
                .weights_i (weights[idx]),
                .nbr_i     (nbr),
                .phase_o   (node_phase[r][c])
            );

            assign gen_clk_o[idx] = node_phase[r][c][`ACC_W-1];
        end
    end

    assign ref_clk_o = ref_phase[`ACC_W-1];

endmodule

// File: pll_node.sv
`include "adpll_grid_settings.svh"

module pll_node #(
    parameter int free_step = `BASE_STEP
) (
    input  logic                              clk258_x,
    input  logic                              rst_n_i,
    input  logic                              enable_i,
    input  adpll_grid_pkg::gains_t            gains_i,
    input  adpll_grid_pkg::node_weights_t     weights_i,
    input  adpll_grid_pkg::neighbour_phases_t nbr_i,
    output adpll_grid_pkg::phase_t            phase_o
);

    adpll_grid_pkg::phase_t   phase_q;
    adpll_grid_pkg::perr_t    err_left;
    adpll_grid_pkg::perr_t    err_above;
    adpll_grid_pkg::perr_t    err_right;
    adpll_grid_pkg::perr_t    err_below;
    logic signed [`ACC_W-1:0] ctrl;

    // top bits of source minus own top bits, wraps as signed
    function automatic adpll_grid_pkg::perr_t phase_err(
        input adpll_grid_pkg::phase_t src,
        input adpll_grid_pkg::phase_t own
    );
        phase_err = src[`ACC_W-1 -: `PDET_W] - own[`ACC_W-1 -: `PDET_W];
    endfunction

    assign err_left  = phase_err(nbr_i.ref_left, phase_q);
    assign err_above = phase_err(nbr_i.ref_above, phase_q);
    assign err_right = phase_err(nbr_i.right, phase_q);
    assign err_below = phase_err(nbr_i.below, phase_q);

    loop_filter u_filter (
        .clk258_x    (clk258_x),
        .rst_n_i     (rst_n_i),
        .enable_i    (enable_i),
        .gains_i     (gains_i),
        .weights_i   (weights_i),
        .err_left_i  (err_left),
        .err_above_i (err_above),
        .err_right_i (err_right),
        .err_below_i (err_below),
        .ctrl_o      (ctrl)
    );

    // node accumulator, stands in for the ring oscillator
    always_ff @(posedge clk258_x)
    begin
        if (!rst_n_i || !enable_i)
            phase_q <= '0;
        else
            phase_q <= phase_q + adpll_grid_pkg::phase_t'(free_step)
                     + adpll_grid_pkg::phase_t'(ctrl);
    end

    assign phase_o = phase_q;

    a_phase_cleared: assert property (
        @(posedge clk258_x) disable iff (!rst_n_i)
        !enable_i |=> (phase_o == '0)
    );

endmodule

// File: loop_filter.sv
`include "adpll_grid_settings.svh"

module loop_filter (
    input  logic                          clk258_x,
    input  logic                          rst_n_i,
    input  logic                          enable_i,
    input  adpll_grid_pkg::gains_t        gains_i,
    input  adpll_grid_pkg::node_weights_t weights_i,
    input  adpll_grid_pkg::perr_t         err_left_i,
    input  adpll_grid_pkg::perr_t         err_above_i,
    input  adpll_grid_pkg::perr_t         err_right_i,
    input  adpll_grid_pkg::perr_t         err_below_i,
    output logic signed [`ACC_W-1:0]      ctrl_o
);

    // 4 terms of at most 15*16 fit in 12 signed bits
    localparam int sum_w = `PDET_W + `WEIGHT_W + 3;

    logic signed [sum_w-1:0]      wsum;
    logic signed [`INTEG_W-1:0]   p_term;
    logic signed [`INTEG_W-1:0]   i_step;
    logic signed [`INTEG_W-1:0]   integ_q;
    logic signed [`INTEG_W-1:0]   ctrl_full;

    function automatic logic signed [sum_w-1:0] weigh(
        input adpll_grid_pkg::weight_t w,
        input adpll_grid_pkg::perr_t   e
    );
        weigh = $signed({1'b0, w}) * e;
    endfunction

    assign wsum = weigh(weights_i.left, err_left_i) + weigh(weights_i.above, err_above_i)
                + weigh(weights_i.right, err_right_i) + weigh(weights_i.below, err_below_i);

    assign p_term = $signed({1'b0, gains_i.kp}) * wsum;
    assign i_step = $signed({1'b0, gains_i.ki}) * wsum;

    always_ff @(posedge clk258_x)
    begin
        if (!rst_n_i || !enable_i)
            integ_q <= '0;
        else
            integ_q <= integ_q + i_step;    // wraps at INTEG_W
    end

    // old integrator, so ctrl lines up with the phase update
    assign ctrl_full = (p_term >>> `KP_FRAC) + (integ_q >>> `KI_FRAC);
    assign ctrl_o    = ctrl_full[`ACC_W-1:0];

    a_integ_cleared: assert property (
        @(posedge clk258_x) disable iff (!rst_n_i)
        !enable_i |=> (integ_q == '0)
    );

endmodule

// File: ref_nco.sv
`include "adpll_grid_settings.svh"

module ref_nco (
    input  logic                   clk258_x,
    input  logic                   rst_n_i,
    input  adpll_grid_pkg::phase_t ref_step_i,
    output adpll_grid_pkg::phase_t phase_o
);

    adpll_grid_pkg::phase_t phase_q;

    // free running, enable has no say here
    always_ff @(posedge clk258_x)
    begin
        if (!rst_n_i)
            phase_q <= '0;
        else
            phase_q <= phase_q + ref_step_i;    // wraps at 2^ACC_W
    end

    assign phase_o = phase_q;

endmodule

// File: grid_config.sv
`include "adpll_grid_settings.svh"

module grid_config (
    input  logic                          clk258_x,
    input  logic                          rst_n_i,
    input  logic [15:0]                   switches_i,
    output adpll_grid_pkg::grid_cfg_t     cfg_o,
    output adpll_grid_pkg::node_weights_t weights_o [9]
);

    // left/above/right/below, one nibble each, node 11 first
    localparam adpll_grid_pkg::node_weights_t uni_tab [9] = '{
        16'h4000, 16'h4000, 16'h4000,
        16'h0400, 16'h2200, 16'h2200,
        16'h0400, 16'h2200, 16'h2200
    };
    localparam adpll_grid_pkg::node_weights_t mesh_tab [9] = '{
        16'h2011, 16'h1011, 16'h2002,
        16'h0111, 16'h1111, 16'h1101,
        16'h0220, 16'h1210, 16'h2200
    };

    adpll_grid_pkg::grid_cfg_t     cfg_q;
    adpll_grid_pkg::node_weights_t weights_q [9];
    adpll_grid_pkg::coupling_e     coupling_sw;

    assign coupling_sw = adpll_grid_pkg::coupling_e'(switches_i[14]);

    always_ff @(posedge clk258_x)
    begin
        if (!rst_n_i)
        begin
            cfg_q.enable    <= 1'b0;
            cfg_q.grid_mode <= adpll_grid_pkg::GRID_PLL;
            cfg_q.coupling  <= adpll_grid_pkg::COUPLE_MESH;
            cfg_q.gains.kp  <= `GAIN_SEL_W'(1);
            cfg_q.gains.ki  <= `GAIN_SEL_W'(1);
            cfg_q.ref_step  <= `ACC_W'(`REF_STEP_RST);
        end
        else
        begin
            cfg_q.enable    <= switches_i[15];
            cfg_q.coupling  <= coupling_sw;
            cfg_q.grid_mode <= adpll_grid_pkg::grid_mode_e'(switches_i[13]);
            if (switches_i[12])
            begin
                cfg_q.ref_step <= switches_i[11:0];
            end
            else
            begin
                cfg_q.gains.kp <= switches_i[11:8];
                cfg_q.gains.ki <= switches_i[3:0];
            end
        end
    end

    // table row follows the switch directly, same latency as cfg
    always_ff @(posedge clk258_x)
    begin
        for (int n = 0; n < 9; n++)
        begin
            if (!rst_n_i)
                weights_q[n] <= mesh_tab[n];    // coupling resets to mesh
            else if (coupling_sw == adpll_grid_pkg::COUPLE_UNI)
                weights_q[n] <= uni_tab[n];
            else
                weights_q[n] <= mesh_tab[n];
        end
    end

    assign cfg_o     = cfg_q;
    assign weights_o = weights_q;

    // gains-load words must leave the reference step alone
    a_ref_step_held: assert property (
        @(posedge clk258_x) disable iff (!rst_n_i)
        !$past(switches_i[12]) |-> $stable(cfg_q.ref_step)
    );

endmodule

// File: adpll_grid_pkg.sv
`include "adpll_grid_settings.svh"

package adpll_grid_pkg;

    typedef logic [`ACC_W-1:0] phase_t;
    typedef logic signed [`PDET_W-1:0] perr_t;
    typedef logic [`WEIGHT_W-1:0] weight_t;

    typedef struct packed {
        weight_t left;
        weight_t above;
        weight_t right;
        weight_t below;
    } node_weights_t;

    typedef struct packed {
        logic [`GAIN_SEL_W-1:0] kp;
        logic [`GAIN_SEL_W-1:0] ki;
    } gains_t;

    // left and above carry the reference in single-PLL mode
    typedef struct packed {
        phase_t ref_left;
        phase_t ref_above;
        phase_t right;
        phase_t below;
    } neighbour_phases_t;

    typedef enum logic {
        GRID_PLL     = 1'b0,
        GRID_NETWORK = 1'b1
    } grid_mode_e;

    typedef enum logic {
        COUPLE_MESH = 1'b0,
        COUPLE_UNI  = 1'b1
    } coupling_e;

    typedef struct packed {
        logic       enable;
        grid_mode_e grid_mode;
        coupling_e  coupling;
        gains_t     gains;
        phase_t     ref_step;
    } grid_cfg_t;

endpackage

// File: adpll_grid_settings.svh
`ifndef ADPLL_GRID_SETTINGS_SVH
`define ADPLL_GRID_SETTINGS_SVH

// phase accumulators
`define ACC_W        12
`define PDET_W       5    // top phase bits seen by the detector

// weights and gains
`define WEIGHT_W     4
`define GAIN_SEL_W   4
`define KP_FRAC      7
`define KI_FRAC      9
`define INTEG_W      20

// free-running step of every node before its ring offset
`define BASE_STEP    64

`define REF_STEP_RST 21   // reference step out of reset

`endif
